// File: verilog/wg_buffer_pkg.sv
package wg_buffer_pkg;

   localparam int WG_ID_W      = 6;
   localparam int WF_COUNT_W   = 4;
   localparam int VGPR_W       = 11;
   localparam int LDS_W        = 11;
   localparam int WF_SIZE_W    = 6;
   localparam int PC_W         = 32;
   localparam int NUM_ENTRIES  = 16;
   localparam int ENTRY_ADDR_W = 4;

   // fields the allocator looks at before deciding
   typedef struct packed {
      logic [WG_ID_W-1:0]    wg_id;
      logic [WF_COUNT_W-1:0] num_wf;
      logic [VGPR_W-1:0]     vgpr_size;
      logic [LDS_W-1:0]      lds_size;
   } wait_entry_t;

   // fields handed to the GPU once accepted
   typedef struct packed {
      logic [PC_W-1:0]      start_pc;
      logic [WF_SIZE_W-1:0] wf_size;
   } ready_entry_t;

   localparam int WAIT_ENTRY_W  = $bits(wait_entry_t);
   localparam int READY_ENTRY_W = $bits(ready_entry_t);

   typedef enum logic [1:0] {
      IN_IDLE,
      IN_WRITE,
      IN_COMMIT,
      IN_SETTLE
   } intake_state_e;

   typedef enum logic [2:0] {
      AL_IDLE,
      AL_WAIT_RESULT,
      AL_FIND_ACCEPTED,
      AL_CLEAR_ACCEPTED,
      AL_FIND_REJECTED,
      AL_CLEAR_REJECTED,
      AL_GET_NEXT,
      AL_LOAD_OFFER
   } alloc_state_e;

endpackage

// File: verilog/wg_entry_ram.sv
`timescale 1ns/1ps

module wg_entry_ram #(
   parameter int WORD_W = 32,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [WORD_W-1:0] wr_data_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [WORD_W-1:0] rd_data_o
);

   logic [WORD_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read word holds until the next read enable
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_data_o <= '0;
      end else if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// File: verilog/wg_slot_status.sv
`timescale 1ns/1ps

module wg_slot_status (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   set_valid_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] set_addr_i,
   input  logic                                   set_pending_i,
   input  logic                                   clear_pending_i,
   input  logic                                   clear_valid_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] status_addr_i,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] free_slot_o,
   output logic                                   full_o,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] pick_slot_o,
   output logic                                   pick_valid_o,
   output logic                                   pending_o
);
   import wg_buffer_pkg::*;

   logic [NUM_ENTRIES-1:0]  valid_q;
   logic [NUM_ENTRIES-1:0]  pending_q;
   logic [NUM_ENTRIES-1:0]  cand;
   logic [ENTRY_ADDR_W-1:0] last_q;
   logic [ENTRY_ADDR_W-1:0] rr_idx;
   logic [ENTRY_ADDR_W-1:0] pick_slot_d;
   logic                    pick_valid_d;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q   <= '0;
         pending_q <= '0;
         // first offer after reset lands on slot 0
         last_q    <= '1;
      end else begin
         if (set_valid_i) begin
            valid_q[set_addr_i] <= 1'b1;
         end
         if (clear_valid_i) begin
            valid_q[status_addr_i] <= 1'b0;
         end
         // a start marks the slot pending and moves the pointer
         if (set_pending_i) begin
            pending_q[status_addr_i] <= 1'b1;
            last_q                   <= status_addr_i;
         end
         if (clear_pending_i) begin
            pending_q[status_addr_i] <= 1'b0;
         end
      end
   end

   assign full_o    = &valid_q;
   assign cand      = valid_q & ~pending_q;
   assign pending_o = pending_q[status_addr_i];

   // lowest free slot wins
   always_comb begin
      free_slot_o = '0;
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
         if (!valid_q[i]) begin
            free_slot_o = ENTRY_ADDR_W'(i);
         end
      end
   end

   // first candidate strictly after the last started slot
   always_comb begin
      pick_valid_d = 1'b0;
      pick_slot_d  = '0;
      rr_idx       = '0;
      for (int i = 1; i <= NUM_ENTRIES; i++) begin
         rr_idx = last_q + ENTRY_ADDR_W'(i);
         if (!pick_valid_d && cand[rr_idx]) begin
            pick_valid_d = 1'b1;
            pick_slot_d  = rr_idx;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pick_valid_o <= 1'b0;
         pick_slot_o  <= '0;
      end else begin
         pick_valid_o <= pick_valid_d;
         pick_slot_o  <= pick_slot_d;
      end
   end

endmodule

// File: verilog/wg_walk_counter.sv
`timescale 1ns/1ps

module wg_walk_counter (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   start_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] start_addr_i,
   input  logic                                   step_i,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] idx_o,
   output logic                                   rd_en_o,
   output logic                                   rd_valid_o
);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         idx_o      <= '0;
         rd_en_o    <= 1'b0;
         rd_valid_o <= 1'b0;
      end else begin
         rd_en_o    <= 1'b0;
         // ram data shows up one cycle after the enable
         rd_valid_o <= rd_en_o;
         if (start_i) begin
            idx_o   <= start_addr_i;
            rd_en_o <= 1'b1;
         end else if (step_i) begin
            idx_o   <= idx_o + 1'b1;
            rd_en_o <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/wg_intake_fsm.sv
`timescale 1ns/1ps

module wg_intake_fsm (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   host_valid_i,
   input  wg_buffer_pkg::wait_entry_t             host_wait_i,
   input  wg_buffer_pkg::ready_entry_t            host_ready_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] free_slot_i,
   input  logic                                   full_i,
   output logic                                   wr_en_o,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] wr_addr_o,
   output wg_buffer_pkg::wait_entry_t             wait_word_o,
   output wg_buffer_pkg::ready_entry_t            ready_word_o,
   output logic                                   set_valid_o,
   output logic                                   host_ack_o
);
   import wg_buffer_pkg::*;

   intake_state_e state_q;
   logic          settle_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q  <= IN_IDLE;
         settle_q <= 1'b0;
      end else begin
         case (state_q)
            IN_IDLE: begin
               // no ack while every slot is taken
               if (host_valid_i && !full_i) begin
                  state_q <= IN_WRITE;
               end
            end
            IN_WRITE: begin
               state_q <= IN_COMMIT;
            end
            IN_COMMIT: begin
               settle_q <= 1'b0;
               state_q  <= IN_SETTLE;
            end
            IN_SETTLE: begin
               // registered host valid needs two cycles to drop
               settle_q <= 1'b1;
               if (settle_q) begin
                  state_q <= IN_IDLE;
               end
            end
            default: state_q <= IN_IDLE;
         endcase
      end
   end

   // slot and words frozen when leaving idle
   always_ff @(posedge clk) begin
      if (state_q == IN_IDLE) begin
         wr_addr_o    <= free_slot_i;
         wait_word_o  <= host_wait_i;
         ready_word_o <= host_ready_i;
      end
   end

   assign wr_en_o     = (state_q == IN_WRITE);
   assign host_ack_o  = (state_q == IN_WRITE);
   assign set_valid_o = (state_q == IN_COMMIT);

endmodule

// File: verilog/wg_alloc_fsm.sv
`timescale 1ns/1ps

module wg_alloc_fsm (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   start_alloc_i,
   input  logic                                   wg_accepted_i,
   input  logic                                   wg_rejected_i,
   input  logic [wg_buffer_pkg::WG_ID_W-1:0]      result_wg_id_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] pick_slot_i,
   input  logic                                   pick_valid_i,
   input  logic                                   pending_i,
   input  logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] walk_idx_i,
   input  logic                                   walk_rd_valid_i,
   input  wg_buffer_pkg::wait_entry_t             wait_rd_i,
   input  wg_buffer_pkg::ready_entry_t            ready_rd_i,
   output logic                                   walk_start_o,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] walk_addr_o,
   output logic                                   walk_step_o,
   output logic                                   set_pending_o,
   output logic                                   clear_pending_o,
   output logic                                   clear_valid_o,
   output logic [wg_buffer_pkg::ENTRY_ADDR_W-1:0] status_addr_o,
   output logic                                   alloc_valid_o,
   output logic                                   alloc_available_o,
   output logic [wg_buffer_pkg::WG_ID_W-1:0]      alloc_wg_id_o,
   output logic [wg_buffer_pkg::WF_COUNT_W-1:0]   alloc_num_wf_o,
   output logic [wg_buffer_pkg::VGPR_W-1:0]       alloc_vgpr_size_o,
   output logic [wg_buffer_pkg::LDS_W-1:0]        alloc_lds_size_o,
   output logic                                   gpu_valid_o,
   output logic [wg_buffer_pkg::PC_W-1:0]         gpu_start_pc_o,
   output logic [wg_buffer_pkg::WF_SIZE_W-1:0]    gpu_wf_size_o
);
   import wg_buffer_pkg::*;

   alloc_state_e            state_q;
   wait_entry_t             offer_q;
   logic [ENTRY_ADDR_W-1:0] offer_slot_q;
   logic                    acc_q;
   logic                    rej_q;
   logic [WG_ID_W-1:0]      res_id_q;
   logic                    id_match;

   // pending entry whose id equals the reported one
   assign id_match = walk_rd_valid_i && pending_i && (wait_rd_i.wg_id == res_id_q);

   // results may arrive while the walk is busy
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_q <= 1'b0;
         rej_q <= 1'b0;
      end else begin
         if (state_q == AL_WAIT_RESULT) begin
            acc_q <= 1'b0;
            rej_q <= 1'b0;
         end
         if (wg_accepted_i) begin
            acc_q <= 1'b1;
         end
         if (wg_rejected_i) begin
            rej_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wg_accepted_i || wg_rejected_i) begin
         res_id_q <= result_wg_id_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q       <= AL_IDLE;
         alloc_valid_o <= 1'b0;
         gpu_valid_o   <= 1'b0;
      end else begin
         gpu_valid_o <= 1'b0;
         case (state_q)
            AL_IDLE: begin
               if (start_alloc_i && alloc_valid_o) begin
                  alloc_valid_o <= 1'b0;
                  state_q       <= AL_WAIT_RESULT;
               end else if (!alloc_valid_o && pick_valid_i) begin
                  state_q <= AL_GET_NEXT;
               end
            end
            AL_WAIT_RESULT: begin
               if (acc_q) begin
                  state_q <= AL_FIND_ACCEPTED;
               end else if (rej_q) begin
                  state_q <= AL_FIND_REJECTED;
               end
            end
            AL_FIND_ACCEPTED: begin
               if (id_match) begin
                  state_q <= AL_CLEAR_ACCEPTED;
               end
            end
            AL_CLEAR_ACCEPTED: begin
               gpu_valid_o <= 1'b1;
               state_q     <= AL_GET_NEXT;
            end
            AL_FIND_REJECTED: begin
               if (id_match) begin
                  state_q <= AL_CLEAR_REJECTED;
               end
            end
            AL_CLEAR_REJECTED: state_q <= AL_GET_NEXT;
            AL_GET_NEXT: state_q <= pick_valid_i ? AL_LOAD_OFFER : AL_IDLE;
            AL_LOAD_OFFER: begin
               if (walk_rd_valid_i) begin
                  alloc_valid_o <= 1'b1;
                  state_q       <= AL_IDLE;
               end
            end
            default: state_q <= AL_IDLE;
         endcase
      end
   end

   // offer fields and gpu payload
   always_ff @(posedge clk) begin
      if (state_q == AL_GET_NEXT) begin
         offer_slot_q <= pick_slot_i;
      end
      if (state_q == AL_LOAD_OFFER && walk_rd_valid_i) begin
         offer_q <= wait_rd_i;
      end
      if (state_q == AL_CLEAR_ACCEPTED) begin
         gpu_start_pc_o <= ready_rd_i.start_pc;
         gpu_wf_size_o  <= ready_rd_i.wf_size;
      end
   end

   // search walks start at slot 0, offer reads at the picked slot
   assign walk_start_o = (state_q == AL_WAIT_RESULT && (acc_q || rej_q)) ||
                         (state_q == AL_GET_NEXT && pick_valid_i);
   assign walk_addr_o  = (state_q == AL_GET_NEXT) ? pick_slot_i : '0;
   assign walk_step_o  = (state_q == AL_FIND_ACCEPTED || state_q == AL_FIND_REJECTED) &&
                         walk_rd_valid_i && !id_match;

   assign set_pending_o   = (state_q == AL_IDLE) && start_alloc_i && alloc_valid_o;
   assign clear_pending_o = (state_q == AL_CLEAR_ACCEPTED) || (state_q == AL_CLEAR_REJECTED);
   assign clear_valid_o   = (state_q == AL_CLEAR_ACCEPTED);
   assign status_addr_o   = (state_q == AL_IDLE) ? offer_slot_q : walk_idx_i;

   assign alloc_available_o = (state_q == AL_WAIT_RESULT) ||
                              (state_q == AL_IDLE && !start_alloc_i &&
                               (alloc_valid_o || !pick_valid_i));

   assign alloc_wg_id_o     = offer_q.wg_id;
   assign alloc_num_wf_o    = offer_q.num_wf;
   assign alloc_vgpr_size_o = offer_q.vgpr_size;
   assign alloc_lds_size_o  = offer_q.lds_size;

endmodule

// File: verilog/inflight_wg_buffer.sv
`timescale 1ns/1ps

module inflight_wg_buffer (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 host_valid_i,
   input  logic [wg_buffer_pkg::WG_ID_W-1:0]    host_wg_id_i,
   input  logic [wg_buffer_pkg::WF_COUNT_W-1:0] host_num_wf_i,
   input  logic [wg_buffer_pkg::VGPR_W-1:0]     host_vgpr_size_i,
   input  logic [wg_buffer_pkg::LDS_W-1:0]      host_lds_size_i,
   input  logic [wg_buffer_pkg::WF_SIZE_W-1:0]  host_wf_size_i,
   input  logic [wg_buffer_pkg::PC_W-1:0]       host_start_pc_i,
   output logic                                 host_ack_o,
   input  logic                                 start_alloc_i,
   input  logic                                 wg_accepted_i,
   input  logic                                 wg_rejected_i,
   input  logic [wg_buffer_pkg::WG_ID_W-1:0]    result_wg_id_i,
   output logic                                 alloc_valid_o,
   output logic                                 alloc_available_o,
   output logic [wg_buffer_pkg::WG_ID_W-1:0]    alloc_wg_id_o,
   output logic [wg_buffer_pkg::WF_COUNT_W-1:0] alloc_num_wf_o,
   output logic [wg_buffer_pkg::VGPR_W-1:0]     alloc_vgpr_size_o,
   output logic [wg_buffer_pkg::LDS_W-1:0]      alloc_lds_size_o,
   output logic                                 gpu_valid_o,
   output logic [wg_buffer_pkg::PC_W-1:0]       gpu_start_pc_o,
   output logic [wg_buffer_pkg::WF_SIZE_W-1:0]  gpu_wf_size_o,
   input  logic                                 dealloc_valid_i,
   input  logic [wg_buffer_pkg::WG_ID_W-1:0]    dealloc_wg_id_i,
   output logic                                 host_done_o,
   output logic [wg_buffer_pkg::WG_ID_W-1:0]    host_done_wg_id_o
);
   import wg_buffer_pkg::*;

   logic                    host_valid_q;
   wait_entry_t             host_wait_q;
   ready_entry_t            host_ready_q;
   logic                    dealloc_valid_q;
   logic [WG_ID_W-1:0]      dealloc_id_q;
   logic                    wr_en;
   logic                    set_valid;
   logic [ENTRY_ADDR_W-1:0] wr_addr;
   logic [ENTRY_ADDR_W-1:0] free_slot;
   logic [ENTRY_ADDR_W-1:0] pick_slot;
   logic [ENTRY_ADDR_W-1:0] status_addr;
   logic [ENTRY_ADDR_W-1:0] walk_addr;
   logic [ENTRY_ADDR_W-1:0] walk_idx;
   wait_entry_t             wait_word;
   wait_entry_t             wait_rd;
   ready_entry_t            ready_word;
   ready_entry_t            ready_rd;
   logic                    full;
   logic                    pick_valid;
   logic                    pending;
   logic                    set_pending;
   logic                    clear_pending;
   logic                    clear_valid;
   logic                    walk_start;
   logic                    walk_step;
   logic                    walk_rd_en;
   logic                    walk_rd_valid;

   // control bits of the host and dealloc inputs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         host_valid_q    <= 1'b0;
         dealloc_valid_q <= 1'b0;
         host_done_o     <= 1'b0;
      end else begin
         host_valid_q    <= host_valid_i;
         dealloc_valid_q <= dealloc_valid_i;
         host_done_o     <= dealloc_valid_q;
      end
   end

   always_ff @(posedge clk) begin
      host_wait_q.wg_id      <= host_wg_id_i;
      host_wait_q.num_wf     <= host_num_wf_i;
      host_wait_q.vgpr_size  <= host_vgpr_size_i;
      host_wait_q.lds_size   <= host_lds_size_i;
      host_ready_q.start_pc  <= host_start_pc_i;
      host_ready_q.wf_size   <= host_wf_size_i;
      dealloc_id_q           <= dealloc_wg_id_i;
      host_done_wg_id_o      <= dealloc_id_q;
   end

   wg_entry_ram #(.WORD_W(WAIT_ENTRY_W), .ADDR_W(ENTRY_ADDR_W)) wait_ram (
      .clk(clk), .rst(rst),
      .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wait_word),
      .rd_en_i(walk_rd_en), .rd_addr_i(walk_idx), .rd_data_o(wait_rd)
   );

   wg_entry_ram #(.WORD_W(READY_ENTRY_W), .ADDR_W(ENTRY_ADDR_W)) ready_ram (
      .clk(clk), .rst(rst),
      .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(ready_word),
      .rd_en_i(walk_rd_en), .rd_addr_i(walk_idx), .rd_data_o(ready_rd)
   );

   wg_slot_status slot_status_i (
      .clk(clk), .rst(rst),
      .set_valid_i(set_valid), .set_addr_i(wr_addr),
      .set_pending_i(set_pending), .clear_pending_i(clear_pending),
      .clear_valid_i(clear_valid), .status_addr_i(status_addr),
      .free_slot_o(free_slot), .full_o(full),
      .pick_slot_o(pick_slot), .pick_valid_o(pick_valid), .pending_o(pending)
   );

   wg_walk_counter walk_counter_i (
      .clk(clk), .rst(rst),
      .start_i(walk_start), .start_addr_i(walk_addr), .step_i(walk_step),
      .idx_o(walk_idx), .rd_en_o(walk_rd_en), .rd_valid_o(walk_rd_valid)
   );

   wg_intake_fsm intake_fsm_i (
      .clk(clk), .rst(rst),
      .host_valid_i(host_valid_q), .host_wait_i(host_wait_q), .host_ready_i(host_ready_q),
      .free_slot_i(free_slot), .full_i(full),
      .wr_en_o(wr_en), .wr_addr_o(wr_addr),
      .wait_word_o(wait_word), .ready_word_o(ready_word),
      .set_valid_o(set_valid), .host_ack_o(host_ack_o)
   );

   wg_alloc_fsm alloc_fsm_i (
      .clk(clk), .rst(rst),
      .start_alloc_i(start_alloc_i), .wg_accepted_i(wg_accepted_i),
      .wg_rejected_i(wg_rejected_i), .result_wg_id_i(result_wg_id_i),
      .pick_slot_i(pick_slot), .pick_valid_i(pick_valid), .pending_i(pending),
      .walk_idx_i(walk_idx), .walk_rd_valid_i(walk_rd_valid),
      .wait_rd_i(wait_rd), .ready_rd_i(ready_rd),
      .walk_start_o(walk_start), .walk_addr_o(walk_addr), .walk_step_o(walk_step),
      .set_pending_o(set_pending), .clear_pending_o(clear_pending),
      .clear_valid_o(clear_valid), .status_addr_o(status_addr),
      .alloc_valid_o(alloc_valid_o), .alloc_available_o(alloc_available_o),
      .alloc_wg_id_o(alloc_wg_id_o), .alloc_num_wf_o(alloc_num_wf_o),
      .alloc_vgpr_size_o(alloc_vgpr_size_o), .alloc_lds_size_o(alloc_lds_size_o),
      .gpu_valid_o(gpu_valid_o), .gpu_start_pc_o(gpu_start_pc_o),
      .gpu_wf_size_o(gpu_wf_size_o)
   );

endmodule

// File: tb/tb_inflight_wg_buffer.sv
`timescale 1ns/1ps

module tb_inflight_wg_buffer;
   import wg_buffer_pkg::*;

   localparam int CLK_PERIOD_NS   = 4;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_TESTS       = 5;
   localparam int MAX_TEST_CYCLES = 1200;
   // five tests at their longest plus some margin
   localparam int WATCHDOG_NS     = (NUM_TESTS * MAX_TEST_CYCLES + 1500) * CLK_PERIOD_NS;
   localparam int EVENT_TIMEOUT   = 200;
   localparam int FULL_WAIT       = 50;
   localparam int MAX_WG          = 32;

   logic                    clk;
   logic                    rst;
   logic                    host_valid_i;
   logic [WG_ID_W-1:0]      host_wg_id_i;
   logic [WF_COUNT_W-1:0]   host_num_wf_i;
   logic [VGPR_W-1:0]       host_vgpr_size_i;
   logic [LDS_W-1:0]        host_lds_size_i;
   logic [WF_SIZE_W-1:0]    host_wf_size_i;
   logic [PC_W-1:0]         host_start_pc_i;
   logic                    host_ack_o;
   logic                    start_alloc_i;
   logic                    wg_accepted_i;
   logic                    wg_rejected_i;
   logic [WG_ID_W-1:0]      result_wg_id_i;
   logic                    alloc_valid_o;
   logic                    alloc_available_o;
   logic [WG_ID_W-1:0]      alloc_wg_id_o;
   logic [WF_COUNT_W-1:0]   alloc_num_wf_o;
   logic [VGPR_W-1:0]       alloc_vgpr_size_o;
   logic [LDS_W-1:0]        alloc_lds_size_o;
   logic                    gpu_valid_o;
   logic [PC_W-1:0]         gpu_start_pc_o;
   logic [WF_SIZE_W-1:0]    gpu_wf_size_o;
   logic                    dealloc_valid_i;
   logic [WG_ID_W-1:0]      dealloc_wg_id_i;
   logic                    host_done_o;
   logic [WG_ID_W-1:0]      host_done_wg_id_o;

   // workgroups as the host sent them
   logic [WG_ID_W-1:0]      wg_id_tab   [MAX_WG];
   logic [WF_COUNT_W-1:0]   num_wf_tab  [MAX_WG];
   logic [VGPR_W-1:0]       vgpr_tab    [MAX_WG];
   logic [LDS_W-1:0]        lds_tab     [MAX_WG];
   logic [WF_SIZE_W-1:0]    wf_size_tab [MAX_WG];
   logic [PC_W-1:0]         pc_tab      [MAX_WG];

   logic [31:0]             rng_state;
   int                      error_count;
   int                      check_count;

   inflight_wg_buffer inflight_wg_buffer_i (
      .clk(clk), .rst(rst),
      .host_valid_i(host_valid_i),
      .host_wg_id_i(host_wg_id_i), .host_num_wf_i(host_num_wf_i),
      .host_vgpr_size_i(host_vgpr_size_i), .host_lds_size_i(host_lds_size_i),
      .host_wf_size_i(host_wf_size_i), .host_start_pc_i(host_start_pc_i),
      .host_ack_o(host_ack_o),
      .start_alloc_i(start_alloc_i), .wg_accepted_i(wg_accepted_i),
      .wg_rejected_i(wg_rejected_i), .result_wg_id_i(result_wg_id_i),
      .alloc_valid_o(alloc_valid_o), .alloc_available_o(alloc_available_o),
      .alloc_wg_id_o(alloc_wg_id_o), .alloc_num_wf_o(alloc_num_wf_o),
      .alloc_vgpr_size_o(alloc_vgpr_size_o), .alloc_lds_size_o(alloc_lds_size_o),
      .gpu_valid_o(gpu_valid_o), .gpu_start_pc_o(gpu_start_pc_o),
      .gpu_wf_size_o(gpu_wf_size_o),
      .dealloc_valid_i(dealloc_valid_i), .dealloc_wg_id_i(dealloc_wg_id_i),
      .host_done_o(host_done_o), .host_done_wg_id_o(host_done_wg_id_o)
   );

   always #(CLK_PERIOD_NS / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests never finished", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic void make_wg(input int n);
      wg_id_tab[n]   = WG_ID_W'(next_random());
      num_wf_tab[n]  = WF_COUNT_W'(next_random());
      vgpr_tab[n]    = VGPR_W'(next_random());
      lds_tab[n]     = LDS_W'(next_random());
      wf_size_tab[n] = WF_SIZE_W'(next_random());
      pc_tab[n]      = next_random();
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_missing(input string what);
      $display("t=%0t timeout: %s", $time, what);
      error_count++;
   endtask

   task automatic drive_wg(input int n);
      @(posedge clk);
      host_valid_i     <= 1'b1;
      host_wg_id_i     <= wg_id_tab[n];
      host_num_wf_i    <= num_wf_tab[n];
      host_vgpr_size_i <= vgpr_tab[n];
      host_lds_size_i  <= lds_tab[n];
      host_wf_size_i   <= wf_size_tab[n];
      host_start_pc_i  <= pc_tab[n];
   endtask

   // host drops valid on the edge after the ack
   task automatic wait_ack(input int max_cycles, output bit seen);
      int i;
      seen = 1'b0;
      for (i = 0; i < max_cycles && !seen; i++) begin
         @(posedge clk);
         if (host_ack_o) begin
            host_valid_i <= 1'b0;
            seen = 1'b1;
         end
      end
   endtask

   task automatic send_wg(input int n);
      bit seen;
      drive_wg(n);
      wait_ack(EVENT_TIMEOUT, seen);
      if (!seen) begin
         report_missing($sformatf("host_ack_o never came for workgroup %0d", n));
      end
   endtask

   task automatic expect_offer(input int n);
      int i;
      bit seen;
      seen = 1'b0;
      for (i = 0; i < EVENT_TIMEOUT && !seen; i++) begin
         @(posedge clk);
         seen = alloc_valid_o;
      end
      if (!seen) begin
         report_missing($sformatf("alloc_valid_o never rose for workgroup %0d", n));
      end else begin
         check_value("alloc_wg_id_o", wg_id_tab[n], alloc_wg_id_o);
         check_value("alloc_num_wf_o", num_wf_tab[n], alloc_num_wf_o);
         check_value("alloc_vgpr_size_o", vgpr_tab[n], alloc_vgpr_size_o);
         check_value("alloc_lds_size_o", lds_tab[n], alloc_lds_size_o);
      end
   endtask

   task automatic start_offer();
      start_alloc_i <= 1'b1;
      @(posedge clk);
      start_alloc_i <= 1'b0;
   endtask

   task automatic give_result(input bit accept, input logic [WG_ID_W-1:0] id);
      @(posedge clk);
      wg_accepted_i  <= accept;
      wg_rejected_i  <= !accept;
      result_wg_id_i <= id;
      @(posedge clk);
      wg_accepted_i  <= 1'b0;
      wg_rejected_i  <= 1'b0;
   endtask

   task automatic expect_gpu_issue(input int n);
      int i;
      bit seen;
      seen = 1'b0;
      for (i = 0; i < EVENT_TIMEOUT && !seen; i++) begin
         @(posedge clk);
         seen = gpu_valid_o;
      end
      if (!seen) begin
         report_missing($sformatf("gpu_valid_o never rose for workgroup %0d", n));
      end else begin
         check_value("gpu_start_pc_o", pc_tab[n], gpu_start_pc_o);
         check_value("gpu_wf_size_o", wf_size_tab[n], gpu_wf_size_o);
         // a single cycle pulse
         @(posedge clk);
         check_value("gpu_valid_o", 1'b0, gpu_valid_o);
      end
   endtask

   task automatic accept_offer(input int n);
      expect_offer(n);
      start_offer();
      give_result(1'b1, wg_id_tab[n]);
      expect_gpu_issue(n);
   endtask

   task automatic reject_offer(input int n);
      expect_offer(n);
      start_offer();
      give_result(1'b0, wg_id_tab[n]);
   endtask

   task automatic reset_outputs_low();
      @(posedge clk);
      check_value("host_ack_o", 1'b0, host_ack_o);
      check_value("alloc_valid_o", 1'b0, alloc_valid_o);
      check_value("gpu_valid_o", 1'b0, gpu_valid_o);
      check_value("host_done_o", 1'b0, host_done_o);
      check_value("alloc_available_o", 1'b1, alloc_available_o);
   endtask

   task automatic single_accept();
      bit rose;
      make_wg(0);
      send_wg(0);
      accept_offer(0);
      rose = 1'b0;
      repeat (20) begin
         @(posedge clk);
         if (alloc_valid_o) begin
            rose = 1'b1;
         end
      end
      check_value("alloc_valid_o after accept", 1'b0, rose);
   endtask

   // A, B and C land in slots 0, 1 and 2
   task automatic round_robin_reject();
      int n;
      for (n = 1; n <= 3; n++) begin
         make_wg(n);
         send_wg(n);
      end
      reject_offer(1);
      accept_offer(2);
      accept_offer(3);
      accept_offer(1);
   endtask

   task automatic full_table_stall();
      int n;
      bit early_ack;
      bit late_ack;
      for (n = 4; n < 20; n++) begin
         make_wg(n);
         send_wg(n);
      end
      make_wg(20);
      drive_wg(20);
      wait_ack(FULL_WAIT, early_ack);
      check_value("host_ack_o while full", 1'b0, early_ack);
      // ack may come while the accept is still in flight
      fork
         wait_ack(EVENT_TIMEOUT, late_ack);
         accept_offer(4);
      join
      if (!late_ack) begin
         report_missing("host_ack_o never came after a slot was freed");
      end
   endtask

   task automatic dealloc_done();
      int k;
      logic [WG_ID_W-1:0] id;
      for (k = 0; k < 4; k++) begin
         id = WG_ID_W'(next_random());
         @(posedge clk);
         dealloc_valid_i <= 1'b1;
         dealloc_wg_id_i <= id;
         @(posedge clk);
         dealloc_valid_i <= 1'b0;
         // id only meaningful during the pulse
         dealloc_wg_id_i <= ~id;
         check_value("host_done_o", 1'b0, host_done_o);
         @(posedge clk);
         check_value("host_done_o", 1'b0, host_done_o);
         @(posedge clk);
         check_value("host_done_o", 1'b1, host_done_o);
         check_value("host_done_wg_id_o", id, host_done_wg_id_o);
         @(posedge clk);
         check_value("host_done_o", 1'b0, host_done_o);
      end
   endtask

   initial begin
      clk              = 1'b0;
      rst              = 1'b1;
      host_valid_i     = 1'b0;
      host_wg_id_i     = '0;
      host_num_wf_i    = '0;
      host_vgpr_size_i = '0;
      host_lds_size_i  = '0;
      host_wf_size_i   = '0;
      host_start_pc_i  = '0;
      start_alloc_i    = 1'b0;
      wg_accepted_i    = 1'b0;
      wg_rejected_i    = 1'b0;
      result_wg_id_i   = '0;
      dealloc_valid_i  = 1'b0;
      dealloc_wg_id_i  = '0;
      rng_state        = 32'hc1d7_4eea;
      error_count      = 0;
      check_count      = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      reset_outputs_low();
      single_accept();
      round_robin_reject();
      full_table_stall();
      dealloc_done();
      repeat (5) @(posedge clk);
      $display("%0d checks done, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
verilog/wg_buffer_pkg.sv
verilog/wg_entry_ram.sv
verilog/wg_slot_status.sv
verilog/wg_walk_counter.sv
verilog/wg_intake_fsm.sv
verilog/wg_alloc_fsm.sv
verilog/inflight_wg_buffer.sv
tb/tb_inflight_wg_buffer.sv

// File: Bender.yml
package:
  name: inflight_wg_buffer

sources:
  - verilog/wg_buffer_pkg.sv
  - verilog/wg_entry_ram.sv
  - verilog/wg_slot_status.sv
  - verilog/wg_walk_counter.sv
  - verilog/wg_intake_fsm.sv
  - verilog/wg_alloc_fsm.sv
  - verilog/inflight_wg_buffer.sv
  - target: simulation
    files:
      - tb/tb_inflight_wg_buffer.sv
